// File: compile.f
+incdir+include
src/conv_pkg.sv
src/conv_ifs.sv
src/ahb_slave_regs.sv
src/kernel_window.sv
src/mac_pipeline.sv
src/result_fifo.sv
src/ahb_convolver.sv
tests/tb_clock_gen.sv
tests/tb_ahb_convolver.sv

// File: Makefile
TOP = tb_ahb_convolver
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^Testbench passed$$" $(LOG)

lint:
	verilator --lint-only --timing -f compile.f --top-module $(TOP)
	verilator --lint-only -f compile.f --top-module ahb_convolver

clean:
	rm -rf obj_dir $(LOG)

// File: tests/tb_ahb_convolver.sv
`timescale 1ns/1ns
`include "conv_params.svh"

module tb_ahb_convolver import conv_pkg::*; ();

  localparam int PERIOD = 40;
  localparam int RESET_CYCLES = 8;
  // Status polls before giving up on busy
  localparam int POLL_LIMIT = 16;
  // Scheduled transfers per test, status polls not counted
  localparam int NUM_XFERS = 2 + 39 + 23 + 58 + 8;
  localparam int WATCHDOG_NS = (NUM_XFERS * 8 + RESET_CYCLES) * PERIOD;

  logic       tb_clk;
  logic       reset;
  logic       hsel;
  bus_addr_t  haddr;
  logic [1:0] htrans;
  logic       hwrite;
  bus_data_t  hwdata;
  bus_data_t  hrdata;
  logic       hresp;

  // Reference model state
  column_t    model_kernel [`CONV_TAPS];
  column_t    model_window [`CONV_TAPS];
  int         model_fill;
  result_t    model_queue [$];
  logic       model_overflow;

  int         test_num;
  int         test_errors;
  int         tests_passed;
  int         tests_failed;

  tb_clock_gen #(.PERIOD(PERIOD)) i_clock_gen (.tb_clk(tb_clk));

  ahb_convolver i_ahb_convolver (
    .tb_clk (tb_clk),
    .reset  (reset),
    .hsel   (hsel),
    .haddr  (haddr),
    .htrans (htrans),
    .hwrite (hwrite),
    .hwdata (hwdata),
    .hrdata (hrdata),
    .hresp  (hresp)
  );

  // ****************************************
  // Reference model
  // ****************************************

  // Coefficient times sample, same row and column, summed over all nine
  function automatic result_t window_sum();
    result_t acc;
    acc = '0;
    for (int c = 0; c < `CONV_TAPS; c++) begin
      for (int r = 0; r < `CONV_TAPS; r++) begin
        acc = acc + result_t'(model_kernel[c][4*r +: 4]) * result_t'(model_window[c][4*r +: 4]);
      end
    end
    return acc;
  endfunction

  // Full queue drops the result and flags overflow
  function automatic void model_push(result_t value);
    if (model_queue.size() < `CONV_FIFO_DEPTH) begin
      model_queue.push_back(value);
    end else begin
      model_overflow = 1'b1;
    end
  endfunction

  function automatic result_t model_pop();
    if (model_queue.size() == 0) begin
      return '0;
    end
    return model_queue.pop_front();
  endfunction

  // Idle engine, so busy is expected clear
  function automatic bus_data_t expected_status();
    bus_data_t s;
    s = '0;
    s[`STAT_AVAIL] = (model_queue.size() != 0);
    s[`STAT_OVERFLOW] = model_overflow;
    return s;
  endfunction

  // ****************************************
  // Bus tasks and checks
  // ****************************************

  // Address phase on one falling edge, data phase on the next
  task automatic bus_write(input bus_addr_t addr, input bus_data_t data, output logic resp);
    @(negedge tb_clk);
    hsel = 1'b1;
    haddr = addr;
    htrans = 2'b10;
    hwrite = 1'b1;
    @(negedge tb_clk);
    hsel = 1'b0;
    htrans = 2'b00;
    hwrite = 1'b0;
    hwdata = data;
    resp = hresp;
    // Write takes effect at the end of the data phase
    @(posedge tb_clk);
  endtask

  task automatic bus_read(input bus_addr_t addr, output bus_data_t data, output logic resp);
    @(negedge tb_clk);
    hsel = 1'b1;
    haddr = addr;
    htrans = 2'b10;
    hwrite = 1'b0;
    @(negedge tb_clk);
    hsel = 1'b0;
    htrans = 2'b00;
    // Read data and response are held for the whole data phase
    data = hrdata;
    resp = hresp;
    @(posedge tb_clk);
  endtask

  task automatic report_mismatch(input string what, input bus_data_t got,
                                 input bus_data_t expected);
    $display("[ERROR] %0t ns: %s returned 0x%04h, expected 0x%04h", $time, what, got, expected);
    test_errors++;
  endtask

  task automatic write_expect_ok(input bus_addr_t addr, input bus_data_t data);
    logic resp;
    bus_write(addr, data, resp);
    if (resp !== 1'b0) report_mismatch($sformatf("hresp of write to %0d", addr), 16'(resp), 16'h0);
  endtask

  task automatic read_check(input bus_addr_t addr, input bus_data_t expected, input string what);
    bus_data_t data;
    logic      resp;
    bus_read(addr, data, resp);
    if (resp !== 1'b0) report_mismatch({"hresp of ", what}, 16'(resp), 16'h0);
    if (data !== expected) report_mismatch(what, data, expected);
  endtask

  // Handshake: poll STATUS until busy drops
  task automatic wait_idle();
    bus_data_t status_word;
    logic      resp;
    logic      busy_seen;
    int        polls;
    busy_seen = 1'b1;
    polls = 0;
    while (busy_seen && polls < POLL_LIMIT) begin
      bus_read(`ADDR_STATUS, status_word, resp);
      busy_seen = status_word[`STAT_BUSY];
      // Command strobe is still pending at the first poll
      if (polls == 0 && busy_seen !== 1'b1) begin
        report_mismatch("busy bit of first STATUS poll", 16'(busy_seen), 16'h1);
      end
      polls++;
    end
    if (busy_seen) begin
      $display("Timeout at %0t ns: engine still busy after %0d status polls", $time, polls);
      test_errors++;
    end
  endtask

  task automatic load_kernel();
    for (int c = 0; c < `CONV_TAPS; c++) begin
      model_kernel[c] = column_t'($urandom());
    end
    write_expect_ok(`ADDR_COEFF0, bus_data_t'(model_kernel[0]));
    write_expect_ok(`ADDR_COEFF1, bus_data_t'(model_kernel[1]));
    write_expect_ok(`ADDR_COEFF2, bus_data_t'(model_kernel[2]));
    write_expect_ok(`ADDR_COMMAND, bus_data_t'(1 << `CMD_LOAD_COEFF));
    wait_idle();
  endtask

  // Shift one column into the window, oldest column falls out
  task automatic push_sample_column();
    column_t col;
    col = column_t'($urandom());
    write_expect_ok(`ADDR_SAMPLE, bus_data_t'(col));
    write_expect_ok(`ADDR_COMMAND, bus_data_t'(1 << `CMD_LOAD_SAMPLE));
    model_window[0] = model_window[1];
    model_window[1] = model_window[2];
    model_window[2] = col;
    if (model_fill < `CONV_TAPS) model_fill++;
    if (model_fill == `CONV_TAPS) model_push(window_sum());
    wait_idle();
  endtask

  task automatic read_results(input int count);
    for (int i = 0; i < count; i++) begin
      read_check(`ADDR_RESULT, bus_data_t'(model_pop()), $sformatf("RESULT read %0d", i));
    end
  endtask

  task automatic finish_test(input string name);
    test_num++;
    if (test_errors == 0) begin
      $display("Test %0d %s: PASS", test_num, name);
      tests_passed++;
    end else begin
      $display("Test %0d %s: FAIL with %0d errors", test_num, name, test_errors);
      tests_failed++;
    end
    test_errors = 0;
  endtask

  // ****************************************
  // Test sequence
  // ****************************************
  initial begin
    bus_data_t status_before;
    bus_data_t data;
    logic      resp;
    reset = 1'b1;
    hsel = 1'b0;
    haddr = '0;
    htrans = 2'b00;
    hwrite = 1'b0;
    hwdata = '0;
    void'($urandom(24687));
    model_fill = 0;
    model_overflow = 1'b0;
    for (int c = 0; c < `CONV_TAPS; c++) begin
      model_kernel[c] = '0;
      model_window[c] = '0;
    end
    test_num = 0;
    test_errors = 0;
    tests_passed = 0;
    tests_failed = 0;
    repeat (RESET_CYCLES) @(negedge tb_clk);
    reset = 1'b0;

    // Registers come out of reset cleared
    read_check(`ADDR_STATUS, 16'h0, "STATUS after reset");
    read_check(`ADDR_RESULT, 16'h0, "RESULT after reset");
    finish_test("reset values");

    // First window fills after three columns, then one result per column
    load_kernel();
    repeat (12) push_sample_column();
    read_results(10);
    read_check(`ADDR_STATUS, expected_status(), "STATUS after draining");
    finish_test("result stream");

    // New kernel applies to the columns already held
    load_kernel();
    repeat (6) push_sample_column();
    read_results(6);
    read_check(`ADDR_STATUS, expected_status(), "STATUS after kernel swap");
    finish_test("kernel reload");

    // Four results beyond the depth are lost
    repeat (20) push_sample_column();
    read_results(`CONV_FIFO_DEPTH);
    read_check(`ADDR_STATUS, expected_status(), "STATUS after overflow");
    read_results(1);
    finish_test("queue overflow");

    // Bad transfers flag hresp and change nothing
    // One queued result shows a stray pop, a stray sample load shows busy
    push_sample_column();
    bus_read(`ADDR_STATUS, status_before, resp);
    if (status_before !== expected_status()) begin
      report_mismatch("STATUS before errors", status_before, expected_status());
    end
    bus_write(`ADDR_STATUS, 16'hffff, resp);
    if (resp !== 1'b1) report_mismatch("hresp of STATUS write", 16'(resp), 16'h1);
    bus_write(`ADDR_RESULT, 16'h1234, resp);
    if (resp !== 1'b1) report_mismatch("hresp of RESULT write", 16'(resp), 16'h1);
    bus_write(4'd14, 16'h0002, resp);
    if (resp !== 1'b1) report_mismatch("hresp of write to 14", 16'(resp), 16'h1);
    bus_read(4'd3, data, resp);
    if (resp !== 1'b1) report_mismatch("hresp of read from 3", 16'(resp), 16'h1);
    read_check(`ADDR_STATUS, status_before, "STATUS after errors");
    finish_test("bus errors");

    $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // Watchdog sized from the scheduled transfers
  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired at %0t ns before the tests finished", $time);
    $display("Testbench failed");
    $finish;
  end

endmodule

// File: tests/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen #(
  parameter int PERIOD = 40
) (
  output logic tb_clk
);

  // Free running clock, low at time zero
  initial begin
    tb_clk = 1'b0;
    forever begin
      #(PERIOD / 2) tb_clk = ~tb_clk;
    end
  end

endmodule

// File: src/ahb_convolver.sv
`timescale 1ns/1ns

module ahb_convolver import conv_pkg::*; (
  input  logic       tb_clk,
  input  logic       reset,
  input  logic       hsel,
  input  bus_addr_t  haddr,
  input  logic [1:0] htrans,
  input  logic       hwrite,
  input  bus_data_t  hwdata,
  output bus_data_t  hrdata,
  output logic       hresp
);

  // ****************************************
  // Internal connections
  // ****************************************
  logic    fifo_pop;
  result_t fifo_rd_data;
  logic    fifo_empty;
  logic    fifo_overflow;
  logic    mac_push;
  result_t mac_data;
  logic    mac_busy;

  cmd_if    u_cmd ();
  window_if u_win ();

  // Bus decode, staging registers and status
  ahb_slave_regs i_ahb_slave_regs (
    .tb_clk   (tb_clk),
    .reset    (reset),
    .hsel     (hsel),
    .haddr    (haddr),
    .htrans   (htrans),
    .hwrite   (hwrite),
    .hwdata   (hwdata),
    .hrdata   (hrdata),
    .hresp    (hresp),
    .cmd      (u_cmd.cmd),
    .pop      (fifo_pop),
    .rd_data  (fifo_rd_data),
    .empty    (fifo_empty),
    .overflow (fifo_overflow),
    .busy     (mac_busy)
  );

  kernel_window i_kernel_window (
    .tb_clk (tb_clk),
    .reset  (reset),
    .cmd    (u_cmd.win),
    .win    (u_win.src)
  );

  mac_pipeline i_mac_pipeline (
    .tb_clk (tb_clk),
    .reset  (reset),
    .win    (u_win.sink),
    .push   (mac_push),
    .data   (mac_data),
    .busy   (mac_busy)
  );

  result_fifo i_result_fifo (
    .tb_clk   (tb_clk),
    .reset    (reset),
    .push     (mac_push),
    .wr_data  (mac_data),
    .pop      (fifo_pop),
    .rd_data  (fifo_rd_data),
    .empty    (fifo_empty),
    .overflow (fifo_overflow)
  );

endmodule

// File: src/result_fifo.sv
`timescale 1ns/1ns
`include "conv_params.svh"

module result_fifo import conv_pkg::*; (
  input  logic    tb_clk,
  input  logic    reset,
  input  logic    push,
  input  result_t wr_data,
  input  logic    pop,
  output result_t rd_data,
  output logic    empty,
  output logic    overflow
);

  localparam int DEPTH = `CONV_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);

  result_t          mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             full;
  logic             do_push;
  logic             do_pop;

  assign full = (count == (PTR_W + 1)'(DEPTH));
  assign empty = (count == '0);
  // Push into a full queue is dropped, pop from empty is ignored
  assign do_push = push && !full;
  assign do_pop = pop && !empty;

  // ****************************************
  // Storage
  // ****************************************
  always_ff @(posedge tb_clk) begin
    if (do_push) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  // Pointers wrap on their own with a power of two depth
  always_ff @(posedge tb_clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
      overflow <= 1'b0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;
      if (do_pop) rd_ptr <= rd_ptr + 1'b1;
      count <= count + (PTR_W + 1)'(do_push) - (PTR_W + 1)'(do_pop);
      // Sticky until reset
      if (push && full) overflow <= 1'b1;
    end
  end

  // Head entry, zero when nothing is queued
  assign rd_data = empty ? '0 : mem[rd_ptr];

  // Occupancy never goes past the depth
  a_count_range: assert property (@(posedge tb_clk) disable iff (reset)
    count <= (PTR_W + 1)'(DEPTH));

endmodule

// File: src/mac_pipeline.sv
`timescale 1ns/1ns
`include "conv_params.svh"

module mac_pipeline import conv_pkg::*; (
  input  logic      tb_clk,
  input  logic      reset,
  window_if.sink    win,
  output logic      push,
  output result_t   data,
  output logic      busy
);

  localparam int NPROD = `CONV_TAPS * `CONV_TAPS;

  product_t   prod_q [NPROD];
  result_t    sum;
  result_t    sum_q;
  // Bit 0 marks products in flight, bit 1 marks the sum
  logic [1:0] vld_q;

  // Pick one row of a column, row 0 is the top nibble
  function automatic tap_t tap_of(column_t col, int row);
    tap_of = col[(`CONV_TAPS - 1 - row) * `CONV_TAP_W +: `CONV_TAP_W];
  endfunction

  // ****************************************
  // Stage 1 multipliers
  // ****************************************
  always_ff @(posedge tb_clk) begin
    for (int c = 0; c < `CONV_TAPS; c++) begin
      for (int r = 0; r < `CONV_TAPS; r++) begin
        prod_q[c * `CONV_TAPS + r] <= product_t'(tap_of(win.kernel[c], r)) *
                                      product_t'(tap_of(win.samples[c], r));
      end
    end
  end

  // ****************************************
  // Stage 2 adder tree
  // ****************************************

  // Nine 8 bit products fit easily in 16 bits
  always_comb begin
    sum = '0;
    for (int i = 0; i < NPROD; i++) begin
      sum = sum + result_t'(prod_q[i]);
    end
  end

  always_ff @(posedge tb_clk) begin
    sum_q <= sum;
  end

  // Valid tracking, up to two windows in flight
  always_ff @(posedge tb_clk) begin
    if (reset) begin
      vld_q <= '0;
    end else begin
      vld_q <= {vld_q[0], win.valid};
    end
  end

  assign push = vld_q[1];
  assign data = sum_q;
  // Includes the cycle a window is handed over
  assign busy = win.valid || (|vld_q);

endmodule

// File: src/kernel_window.sv
`timescale 1ns/1ns
`include "conv_params.svh"

module kernel_window import conv_pkg::*; (
  input logic   tb_clk,
  input logic   reset,
  cmd_if.win    cmd,
  window_if.src win
);

  kernel_t kernel_q;
  kernel_t samples_q;
  fill_t   fill_q;
  logic    valid_q;

  // ****************************************
  // Kernel store and fill control
  // ****************************************
  always_ff @(posedge tb_clk) begin
    if (reset) begin
      kernel_q <= '0;
      fill_q <= '0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      // Whole kernel replaced, window contents kept
      if (cmd.load_coeff) begin
        kernel_q <= cmd.coeff_cols;
      end
      if (cmd.load_sample) begin
        // Count saturates once the window holds three columns
        if (fill_q != fill_t'(`CONV_TAPS)) begin
          fill_q <= fill_q + 2'd1;
        end
        // Window is full after this shift
        valid_q <= (fill_q >= fill_t'(`CONV_TAPS - 1));
      end
    end
  end

  // ****************************************
  // Sliding sample window
  // ****************************************

  // Oldest column drops out of slot 0, new column enters slot 2
  always_ff @(posedge tb_clk) begin
    if (cmd.load_sample) begin
      samples_q <= {cmd.sample_col, samples_q[`CONV_TAPS-1:1]};
    end
  end

  assign win.valid = valid_q;
  assign win.kernel = kernel_q;
  assign win.samples = samples_q;

  // Window only fires right after a shift into a full window
  a_fill_full: assert property (@(posedge tb_clk) disable iff (reset)
    valid_q |-> $past(cmd.load_sample) && (fill_q == fill_t'(`CONV_TAPS)));

endmodule

// File: src/ahb_slave_regs.sv
`timescale 1ns/1ns
`include "conv_params.svh"

module ahb_slave_regs import conv_pkg::*; (
  input  logic      tb_clk,
  input  logic      reset,
  input  logic      hsel,
  input  bus_addr_t haddr,
  input  logic [1:0] htrans,
  input  logic      hwrite,
  input  bus_data_t hwdata,
  output bus_data_t hrdata,
  output logic      hresp,
  cmd_if.cmd        cmd,
  output logic      pop,
  input  result_t   rd_data,
  input  logic      empty,
  input  logic      overflow,
  input  logic      busy
);

  // Address phase capture
  logic      accept;
  logic      addr_error;
  logic      dphase_valid;
  logic      dphase_write;
  bus_addr_t dphase_addr;
  logic      wr_en;

  // Staging registers and command strobes
  kernel_t   coeff_stage;
  column_t   sample_stage;
  logic      load_coeff_q;
  logic      load_sample_q;

  bus_data_t status_word;
  bus_data_t read_mux;

  // ****************************************
  // Address phase
  // ****************************************

  // NONSEQ or SEQ while selected
  assign accept = hsel && htrans[1];

  // Writes to read-only registers, odd and unmapped addresses fail
  always_comb begin
    addr_error = 1'b0;
    case (haddr)
      `ADDR_STATUS, `ADDR_RESULT: addr_error = hwrite;
      `ADDR_SAMPLE, `ADDR_COEFF0, `ADDR_COEFF1, `ADDR_COEFF2, `ADDR_COMMAND: addr_error = 1'b0;
      default: addr_error = 1'b1;
    endcase
  end

  // Result read pops the queue at the address phase edge
  assign pop = accept && !hwrite && (haddr == `ADDR_RESULT);

  // Busy also counts a strobe that has not reached the window yet
  always_comb begin
    status_word = '0;
    status_word[`STAT_BUSY] = busy || load_coeff_q || load_sample_q;
    status_word[`STAT_AVAIL] = !empty;
    status_word[`STAT_OVERFLOW] = overflow;
  end

  always_comb begin
    read_mux = '0;
    case (haddr)
      `ADDR_STATUS: read_mux = status_word;
      `ADDR_RESULT: read_mux = bus_data_t'(rd_data);
      `ADDR_SAMPLE: read_mux = bus_data_t'(sample_stage);
      `ADDR_COEFF0: read_mux = bus_data_t'(coeff_stage[0]);
      `ADDR_COEFF1: read_mux = bus_data_t'(coeff_stage[1]);
      `ADDR_COEFF2: read_mux = bus_data_t'(coeff_stage[2]);
      // Command register reads back as zero
      default: read_mux = '0;
    endcase
  end

  // Read data is ready for the whole data phase
  always_ff @(posedge tb_clk) begin
    if (reset) begin
      dphase_valid <= 1'b0;
      dphase_write <= 1'b0;
      dphase_addr <= '0;
      hresp <= 1'b0;
      hrdata <= '0;
    end else begin
      dphase_valid <= accept;
      dphase_write <= hwrite;
      dphase_addr <= haddr;
      hresp <= accept && addr_error;
      hrdata <= (accept && !hwrite && !addr_error) ? read_mux : '0;
    end
  end

  // ****************************************
  // Data phase
  // ****************************************

  // A failed transfer leaves every register alone
  assign wr_en = dphase_valid && dphase_write && !hresp;

  always_ff @(posedge tb_clk) begin
    if (reset) begin
      coeff_stage <= '0;
      sample_stage <= '0;
      load_coeff_q <= 1'b0;
      load_sample_q <= 1'b0;
    end else begin
      load_coeff_q <= 1'b0;
      load_sample_q <= 1'b0;
      if (wr_en) begin
        case (dphase_addr)
          `ADDR_SAMPLE: sample_stage <= hwdata[$bits(column_t)-1:0];
          `ADDR_COEFF0: coeff_stage[0] <= hwdata[$bits(column_t)-1:0];
          `ADDR_COEFF1: coeff_stage[1] <= hwdata[$bits(column_t)-1:0];
          `ADDR_COEFF2: coeff_stage[2] <= hwdata[$bits(column_t)-1:0];
          `ADDR_COMMAND: begin
            // Coefficient load wins when both bits are written
            load_coeff_q <= hwdata[`CMD_LOAD_COEFF];
            load_sample_q <= hwdata[`CMD_LOAD_SAMPLE] && !hwdata[`CMD_LOAD_COEFF];
          end
          default: ;
        endcase
      end
    end
  end

  assign cmd.load_coeff = load_coeff_q;
  assign cmd.load_sample = load_sample_q;
  assign cmd.coeff_cols = coeff_stage;
  assign cmd.sample_col = sample_stage;

  // Strobes are exclusive and only follow a good command write
  a_strobe_source: assert property (@(posedge tb_clk) disable iff (reset)
    (load_coeff_q || load_sample_q) |->
      !(load_coeff_q && load_sample_q) && $past(wr_en && dphase_addr == `ADDR_COMMAND));

  // A popping read never answers with an error
  a_pop_no_error: assert property (@(posedge tb_clk) disable iff (reset)
    pop |=> !hresp);

endmodule

// File: src/conv_ifs.sv
`timescale 1ns/1ns

// ****************************************
// Register file to window commands
// ****************************************
interface cmd_if import conv_pkg::*; ();

  // Single cycle strobes from the command register
  logic load_coeff;
  logic load_sample;
  // Staging registers, valid in the strobe cycle
  kernel_t coeff_cols;
  column_t sample_col;

  modport cmd (
    output load_coeff, load_sample, coeff_cols, sample_col
  );

  modport win (
    input load_coeff, load_sample, coeff_cols, sample_col
  );

endinterface

// ****************************************
// Window to MAC handoff
// ****************************************
interface window_if import conv_pkg::*; ();

  // One cycle per completed window
  logic valid;
  kernel_t kernel;
  kernel_t samples;

  modport src (
    output valid, kernel, samples
  );

  modport sink (
    input valid, kernel, samples
  );

endinterface

// File: src/conv_pkg.sv
`include "conv_params.svh"

package conv_pkg;

  // ****************************************
  // Datapath types
  // ****************************************

  // One coefficient or one sample
  typedef logic [`CONV_TAP_W-1:0] tap_t;

  // Three taps stacked, row 0 in the top nibble
  typedef logic [`CONV_TAPS*`CONV_TAP_W-1:0] column_t;

  // Three columns, index 0 is the oldest column of the window
  typedef column_t [`CONV_TAPS-1:0] kernel_t;

  // Full width product of two taps
  typedef logic [2*`CONV_TAP_W-1:0] product_t;

  // Sum of all nine products
  typedef logic [`CONV_DATA_W-1:0] result_t;

  // ****************************************
  // Bus types
  // ****************************************
  typedef logic [`CONV_DATA_W-1:0] bus_data_t;
  typedef logic [`CONV_ADDR_W-1:0] bus_addr_t;

  // Number of valid columns held in the window
  typedef logic [1:0] fill_t;

endpackage

// File: include/conv_params.svh
`ifndef CONV_PARAMS_SVH
`define CONV_PARAMS_SVH

// Bus and datapath widths
`define CONV_DATA_W 16
`define CONV_ADDR_W 4
`define CONV_TAP_W 4
`define CONV_TAPS 3
// Result queue depth, any power of two
`define CONV_FIFO_DEPTH 16

// Register map, even addresses only
`define ADDR_STATUS 4'd0
`define ADDR_RESULT 4'd2
`define ADDR_SAMPLE 4'd4
`define ADDR_COEFF0 4'd6
`define ADDR_COEFF1 4'd8
`define ADDR_COEFF2 4'd10
`define ADDR_COMMAND 4'd12

// Command register bit positions
`define CMD_LOAD_COEFF 0
`define CMD_LOAD_SAMPLE 1

// Status register bit positions
`define STAT_BUSY 0
`define STAT_AVAIL 1
`define STAT_OVERFLOW 2

`endif
